//--- hw/apb_pkg.sv
`default_nettype none

package apb_pkg;

	////////////////////
	// Bus widths
	////////////////////

	// Byte address into the completer space
	localparam int ADDR_W = 12;
	localparam int DATA_W = 32;
	localparam int BYTE_W = 8;
	// One strobe bit per byte lane
	localparam int STRB_W = DATA_W / BYTE_W;
	localparam int PROT_W = 3;

	////////////////////
	// Sizes and depths
	////////////////////

	localparam int NUM_REGS = 16;
	localparam int REG_IDX_W = $clog2(NUM_REGS);
	// Command queue in front of the master
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	// Count needs one more value than the pointers
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
	// Longest stall the completer produces
	localparam int MAX_WAIT = 3;
	localparam int WAIT_W = $clog2(MAX_WAIT + 1);

	////////////////////
	// Basic types
	////////////////////

	typedef logic [ADDR_W-1:0] apb_addr_t;
	typedef logic [DATA_W-1:0] apb_data_t;
	typedef logic [STRB_W-1:0] apb_strb_t;
	// Bit 0 set means privileged access
	typedef logic [PROT_W-1:0] apb_prot_t;

	// One queued command
	typedef struct packed {
		logic      write;
		apb_addr_t addr;
		apb_data_t wdata;
		apb_strb_t strb;
		apb_prot_t prot;
	} apb_cmd_t;

	// Response returned after completion
	typedef struct packed {
		logic      write;
		apb_addr_t addr;
		apb_data_t rdata;
		logic      err;
	} apb_rsp_t;

	// Requester side of the APB bus
	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
		apb_strb_t pstrb;
		apb_prot_t pprot;
	} apb_req_t;

	// Completer side of the APB bus
	typedef struct packed {
		logic      pready;
		apb_data_t prdata;
		logic      pslverr;
	} apb_cpl_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS
	} master_state_t;

endpackage

`default_nettype wire

//--- hw/apb_cmd_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module apb_cmd_fifo (
	input  logic              PCLK,
	input  logic              reset,
	input  logic              cmd_valid,
	input  apb_pkg::apb_cmd_t cmd,
	input  logic              q_pop,
	output logic              q_valid,
	output apb_pkg::apb_cmd_t q_cmd,
	output logic              cmd_drop
);
	import apb_pkg::*;

	// Entry storage
	apb_cmd_t mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	// Occupancy from 0 up to FIFO_DEPTH
	logic [FIFO_CNT_W-1:0] count;
	logic full;
	logic push;
	logic pop;

	////////////////////
	// Push and pop qualification
	////////////////////

	assign full = (count == FIFO_CNT_W'(FIFO_DEPTH));
	// Pop only counts when something is there
	assign pop = q_pop && q_valid;
	// A full queue still takes a push when the head leaves this cycle
	assign push = cmd_valid && (!full || pop);

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge PCLK)
	begin
		if (push)
			mem[wr_ptr] <= cmd;
	end

	////////////////////
	// Pointers and count
	////////////////////

	// Pointers wrap naturally since the depth is a power of two
	always_ff @(posedge PCLK)
	begin
		if (reset)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			cmd_drop <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Strobe that found no room is lost
			cmd_drop <= cmd_valid && !push;
		end
	end

	// Head of queue straight from storage
	assign q_valid = (count != '0);
	assign q_cmd   = mem[rd_ptr];

endmodule

`default_nettype wire

//--- hw/apb_master.sv
`timescale 1ns/1ns
`default_nettype none

module apb_master (
	input  logic              PCLK,
	input  logic              reset,
	input  logic              q_valid,
	input  apb_pkg::apb_cmd_t q_cmd,
	output logic              q_pop,
	output apb_pkg::apb_req_t req,
	input  apb_pkg::apb_cpl_t cpl,
	output logic              rsp_valid,
	output apb_pkg::apb_rsp_t rsp
);
	import apb_pkg::*;

	master_state_t state;
	master_state_t state_nxt;
	// Command held for the whole transfer
	apb_cmd_t cmd_r;
	// Completing access cycle
	logic done;

	////////////////////
	// Queue handshake
	////////////////////

	// Take a new command only from idle
	assign q_pop = (state == ST_IDLE) && q_valid;
	assign done  = (state == ST_ACCESS) && cpl.pready;

	always_ff @(posedge PCLK)
	begin
		if (q_pop)
			cmd_r <= q_cmd;
	end

	////////////////////
	// Transfer FSM
	////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
			begin
				if (q_valid)
					state_nxt = ST_SETUP;
			end
			// Setup always lasts one cycle
			ST_SETUP:
				state_nxt = ST_ACCESS;
			ST_ACCESS:
			begin
				// Stay here while the completer stalls
				if (cpl.pready)
					state_nxt = ST_IDLE;
			end
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge PCLK)
	begin
		if (reset)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	////////////////////
	// Bus drive
	////////////////////

	// All fields come from the held command so they stay put during a stall
	always_comb
	begin
		req.psel    = (state != ST_IDLE);
		req.penable = (state == ST_ACCESS);
		req.pwrite  = cmd_r.write;
		req.paddr   = cmd_r.addr;
		req.pwdata  = cmd_r.wdata;
		req.pstrb   = cmd_r.strb;
		req.pprot   = cmd_r.prot;
	end

	////////////////////
	// Response register
	////////////////////

	always_ff @(posedge PCLK)
	begin
		if (reset)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= done;
	end

	// Capture read data and error in the completing cycle
	always_ff @(posedge PCLK)
	begin
		if (done)
		begin
			rsp.write <= cmd_r.write;
			rsp.addr  <= cmd_r.addr;
			rsp.rdata <= cpl.prdata;
			rsp.err   <= cpl.pslverr;
		end
	end

endmodule

`default_nettype wire

//--- hw/apb_regbank.sv
`timescale 1ns/1ns
`default_nettype none

module apb_regbank (
	input  logic              PCLK,
	input  logic              reset,
	input  apb_pkg::apb_req_t req,
	output apb_pkg::apb_cpl_t cpl
);
	import apb_pkg::*;

	apb_data_t regs [NUM_REGS];
	// Access cycles already spent stalling
	logic [WAIT_W-1:0] wait_cnt;
	// Stall length wanted for this address
	logic [WAIT_W-1:0] wait_need;
	logic [REG_IDX_W-1:0] idx;
	logic access;
	logic complete;
	logic out_of_range;
	logic priv_fault;
	logic err;

	////////////////////
	// Address decode
	////////////////////

	// Word index from the byte address
	assign idx       = req.paddr[2 +: REG_IDX_W];
	// Wait states follow the low word index bits
	assign wait_need = req.paddr[2 +: WAIT_W];
	// Anything above the register window
	assign out_of_range = (req.paddr[ADDR_W-1:REG_IDX_W+2] != '0);
	// Last register is write protected for user accesses
	assign priv_fault = req.pwrite && (idx == REG_IDX_W'(NUM_REGS - 1))
		&& !req.pprot[0];
	assign err = out_of_range || priv_fault;

	////////////////////
	// Wait states
	////////////////////

	assign access   = req.psel && req.penable;
	assign complete = access && (wait_cnt == wait_need);

	// Counter runs only through the stalled access cycles
	always_ff @(posedge PCLK)
	begin
		if (reset)
			wait_cnt <= '0;
		else if (access && !complete)
			wait_cnt <= wait_cnt + 1'b1;
		else
			wait_cnt <= '0;
	end

	////////////////////
	// Register array
	////////////////////

	always_ff @(posedge PCLK)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (complete && req.pwrite && !err)
		begin
			// Update only enabled byte lanes
			for (int b = 0; b < STRB_W; b++)
			begin
				if (req.pstrb[b])
					regs[idx][BYTE_W*b +: BYTE_W] <= req.pwdata[BYTE_W*b +: BYTE_W];
			end
		end
	end

	////////////////////
	// Completer outputs
	////////////////////

	// Data and error are zero outside the completing cycle
	always_comb
	begin
		cpl.pready  = complete;
		cpl.pslverr = complete && err;
		cpl.prdata  = '0;
		if (complete && !err && !req.pwrite)
			cpl.prdata = regs[idx];
	end

endmodule

`default_nettype wire

//--- hw/apb_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module apb_subsys_top (
	input  logic              PCLK,
	input  logic              reset,
	input  logic              cmd_valid,
	input  apb_pkg::apb_cmd_t cmd,
	output logic              cmd_drop,
	output logic              rsp_valid,
	output apb_pkg::apb_rsp_t rsp,
	output apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_cpl_t apb_cpl
);
	import apb_pkg::*;

	// Queue to master handshake
	logic     q_valid;
	logic     q_pop;
	apb_cmd_t q_cmd;

	////////////////////
	// Command queue
	////////////////////

	apb_cmd_fifo u_fifo (
		.PCLK      (PCLK),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.q_pop     (q_pop),
		.q_valid   (q_valid),
		.q_cmd     (q_cmd),
		.cmd_drop  (cmd_drop)
	);

	////////////////////
	// APB requester
	////////////////////

	apb_master u_master (
		.PCLK      (PCLK),
		.reset     (reset),
		.q_valid   (q_valid),
		.q_cmd     (q_cmd),
		.q_pop     (q_pop),
		.req       (apb_req),
		.cpl       (apb_cpl),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	// Register bank on the far side of the bus
	apb_regbank u_regbank (
		.PCLK  (PCLK),
		.reset (reset),
		.req   (apb_req),
		.cpl   (apb_cpl)
	);

endmodule

`default_nettype wire

//--- tb/apb_protocol_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module apb_protocol_asserts (
	input logic              PCLK,
	input logic              reset,
	input apb_pkg::apb_req_t req,
	input apb_pkg::apb_cpl_t cpl
);
	import apb_pkg::*;

	// Access cycle held off by the completer
	logic stalled;
	// Access cycle that ends the transfer
	logic completing;

	assign stalled    = req.psel && req.penable && !cpl.pready;
	assign completing = req.psel && req.penable && cpl.pready;

	////////////////////
	// Reset state
	////////////////////

	// Bus is quiet in the cycle after reset
	reset_idle: assert property (@(posedge PCLK) reset |=> !req.psel && !req.penable)
		else $error("PSEL or PENABLE high in the cycle after reset");

	////////////////////
	// Phase sequence
	////////////////////

	// One setup cycle, then access
	setup_then_access: assert property (@(posedge PCLK) disable iff (reset)
		req.psel && !req.penable |=> req.psel && req.penable)
		else $error("Setup phase not followed by access phase");

	// Enable stays up through a stall and drops after completion
	stall_keeps_enable: assert property (@(posedge PCLK) disable iff (reset)
		stalled |=> req.psel && req.penable)
		else $error("PENABLE or PSEL dropped during a stalled access");
	enable_drops: assert property (@(posedge PCLK) disable iff (reset)
		completing |=> !req.penable)
		else $error("PENABLE still high after the completing cycle");

	// Request fields hold from setup until completion
	fields_stable: assert property (@(posedge PCLK) disable iff (reset)
		req.psel && !completing |=>
		$stable({req.pwrite, req.paddr, req.pwdata, req.pstrb, req.pprot}))
		else $error("Request fields changed before the transfer completed");

	////////////////////
	// Completer response
	////////////////////

	// Stall bounded by the largest wait count
	stall_bound: assert property (@(posedge PCLK) disable iff (reset)
		$rose(req.penable) |-> ##[0:MAX_WAIT] cpl.pready)
		else $error("Access phase stalled longer than MAX_WAIT cycles");

	// Error only alongside PREADY in an access cycle
	slverr_on_complete: assert property (@(posedge PCLK) disable iff (reset)
		cpl.pslverr |-> completing)
		else $error("PSLVERR raised outside a completing access cycle");

endmodule

`default_nettype wire

//--- tb/apb_subsys_tb.sv
`timescale 1ns/1ns
`default_nettype none

module apb_subsys_tb;
	import apb_pkg::*;

	localparam int RAND_CMDS      = 150;
	localparam int TIMEOUT_CYCLES = 3000;

	logic     PCLK = 1'b0;
	logic     reset;
	logic     cmd_valid;
	apb_cmd_t cmd;
	logic     cmd_drop;
	logic     rsp_valid;
	apb_rsp_t rsp;
	apb_req_t apb_req;
	apb_cpl_t apb_cpl;

	// Reference register contents and pending responses
	apb_data_t model_regs [NUM_REGS];
	apb_rsp_t  exp_q [$];
	apb_rsp_t  exp_rsp;
	// Model of the queue fill level
	int        occupancy = 0;
	logic      pop_now;
	// Transfer taken by the master and not yet answered
	logic      busy = 1'b0;
	logic      drop_exp = 1'b0;
	int        drop_count = 0;
	int        cycle_count = 0;
	integer    seed = 32'hcd7e;
	logic [31:0] rnd;
	int        word;

	always #5 PCLK = ~PCLK;

	apb_subsys_top UUT (
		.PCLK      (PCLK),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_drop  (cmd_drop),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.apb_req   (apb_req),
		.apb_cpl   (apb_cpl)
	);

	// Protocol checker rides along inside the master
	bind apb_master apb_protocol_asserts u_protocol_asserts (
		.PCLK  (PCLK),
		.reset (reset),
		.req   (req),
		.cpl   (cpl)
	);

	////////////////////
	// Helpers
	////////////////////

	task automatic stop_with_failure(input string line);
		$display("%s", line);
		$display("Checks failed");
		$fatal(1);
	endtask

	function automatic apb_cmd_t make_cmd(input logic write, input apb_addr_t addr,
		input apb_data_t wdata, input apb_strb_t strb, input apb_prot_t prot);
		apb_cmd_t c;
		c.write = write;
		c.addr  = addr;
		c.wdata = wdata;
		c.strb  = strb;
		c.prot  = prot;
		return c;
	endfunction

	// Register bank rules applied in command order
	function automatic apb_rsp_t model_access(input apb_cmd_t c);
		apb_rsp_t r;
		int idx;
		logic err;
		idx = (c.addr >> 2) % NUM_REGS;
		err = (c.addr >= NUM_REGS * 4) || (c.write && idx == NUM_REGS - 1 && !c.prot[0]);
		r.write = c.write;
		r.addr  = c.addr;
		r.err   = err;
		r.rdata = '0;
		if (!err && !c.write)
			r.rdata = model_regs[idx];
		// Merge enabled byte lanes only
		for (int b = 0; b < STRB_W; b++)
		begin
			if (!err && c.write && c.strb[b])
				model_regs[idx][BYTE_W*b +: BYTE_W] = c.wdata[BYTE_W*b +: BYTE_W];
		end
		return r;
	endfunction

	// One strobe followed by idle cycles
	task automatic issue(input apb_cmd_t c, input int gap);
		cmd       = c;
		cmd_valid = 1'b1;
		@(posedge PCLK);
		#1;
		cmd_valid = 1'b0;
		repeat (gap)
		begin
			@(posedge PCLK);
			#1;
		end
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
		begin
			@(posedge PCLK);
			#1;
		end
	endtask

	////////////////////
	// Model and checks
	////////////////////

	// Sample mid-cycle where inputs and outputs are settled
	always @(negedge PCLK)
	begin
		if (reset)
		begin
			occupancy = 0;
			busy      = 1'b0;
			drop_exp  = 1'b0;
		end
		else
		begin
			// Drop flag lags its strobe by one cycle
			assert (cmd_drop == drop_exp)
			else stop_with_failure($sformatf("FAILED at %0t: cmd_drop is %b, expected %b",
				$time, cmd_drop, drop_exp));
			if (rsp_valid)
			begin
				assert (exp_q.size() != 0)
				else stop_with_failure("A response arrived with no command outstanding");
				exp_rsp = exp_q.pop_front();
				assert (rsp == exp_rsp)
				else stop_with_failure($sformatf(
					"FAILED at %0t: addr %h got rdata %h err %b, expected addr %h rdata %h err %b",
					$time, rsp.addr, rsp.rdata, rsp.err, exp_rsp.addr, exp_rsp.rdata,
					exp_rsp.err));
			end
			// Master is idle again in the cycle its response shows up
			pop_now  = (!busy || rsp_valid) && (occupancy != 0);
			busy     = pop_now || (busy && !rsp_valid);
			drop_exp = cmd_valid && (occupancy == FIFO_DEPTH) && !pop_now;
			if (drop_exp)
				drop_count++;
			if (cmd_valid && !drop_exp)
				exp_q.push_back(model_access(cmd));
			occupancy = occupancy + int'(cmd_valid && !drop_exp) - int'(pop_now);
		end
	end

	always @(posedge PCLK)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_with_failure($sformatf("Timeout: the run did not finish within %0d cycles",
				TIMEOUT_CYCLES));
	end

	////////////////////
	// Stimulus
	////////////////////

	initial
	begin
		reset     = 1'b1;
		cmd_valid = 1'b0;
		cmd       = '0;
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = '0;
		repeat (10) @(posedge PCLK);
		#1;
		reset = 1'b0;
		assert (!apb_req.psel && !apb_req.penable && !apb_cpl.pready && !apb_cpl.pslverr
			&& !rsp_valid && !cmd_drop)
		else stop_with_failure($sformatf("FAILED at %0t: bus or strobes active after reset",
			$time));
		// Every register starts at zero
		for (int i = 0; i < NUM_REGS; i++)
		begin
			issue(make_cmd(1'b0, apb_addr_t'(i * 4), '0, '0, '0), 0);
			drain();
		end
		// Full write, partial overwrite, read back
		issue(make_cmd(1'b1, 12'h008, 32'h1122_3344, 4'hF, 3'b000), 0);
		issue(make_cmd(1'b1, 12'h008, 32'hAABB_CCDD, 4'b0101, 3'b000), 0);
		issue(make_cmd(1'b0, 12'h008, '0, '0, '0), 0);
		drain();
		// Out of range accesses leave the bank untouched
		issue(make_cmd(1'b1, 12'h040, 32'hDEAD_BEEF, 4'hF, 3'b001), 0);
		issue(make_cmd(1'b0, 12'h044, '0, '0, '0), 0);
		issue(make_cmd(1'b1, 12'hFF8, 32'h0BAD_F00D, 4'hF, 3'b001), 0);
		issue(make_cmd(1'b0, 12'h000, '0, '0, '0), 0);
		issue(make_cmd(1'b0, 12'h038, '0, '0, '0), 0);
		drain();
		// Register 15 needs a privileged write
		issue(make_cmd(1'b1, 12'h03C, 32'h5555_5555, 4'hF, 3'b000), 0);
		issue(make_cmd(1'b0, 12'h03C, '0, '0, '0), 0);
		issue(make_cmd(1'b1, 12'h03C, 32'h0F0F_0F0F, 4'hF, 3'b001), 0);
		issue(make_cmd(1'b0, 12'h03C, '0, '0, '0), 0);
		drain();
		// Random mix over all wait counts and some bad addresses
		for (int n = 0; n < RAND_CMDS; n++)
		begin
			rnd  = $random(seed);
			word = int'(rnd[3:0]) + ((rnd[7:5] == 3'd0) ? NUM_REGS : 0);
			issue(make_cmd(rnd[8], apb_addr_t'(word * 4), $random(seed), rnd[12:9],
				rnd[15:13]), 2 + int'(rnd[17:16]));
		end
		drain();
		// Consecutive strobes keep their order
		issue(make_cmd(1'b1, 12'h010, 32'hCAFE_0001, 4'hF, 3'b000), 0);
		issue(make_cmd(1'b0, 12'h010, '0, '0, '0), 0);
		issue(make_cmd(1'b1, 12'h020, 32'hCAFE_0002, 4'hF, 3'b000), 0);
		issue(make_cmd(1'b0, 12'h020, '0, '0, '0), 0);
		drain();
		// Flood slow addresses until the queue overflows
		for (int i = 0; i < 12; i++)
			issue(make_cmd(i % 2 == 1, apb_addr_t'((i % 4) * 16 + 12), $random(seed), 4'hF,
				3'b001), 0);
		drain();
		repeat (10) @(posedge PCLK);
		if (drop_count != 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
			stop_with_failure("The overflow burst never filled the command queue");
	end

endmodule

`default_nettype wire

//--- sim.f
hw/apb_pkg.sv
hw/apb_cmd_fifo.sv
hw/apb_master.sv
hw/apb_regbank.sv
hw/apb_subsys_top.sv
tb/apb_protocol_asserts.sv
tb/apb_subsys_tb.sv

//--- Bender.yml
package:
  name: apb_subsys

sources:
  # Synthesizable design in compile order
  - files:
      - hw/apb_pkg.sv
      - hw/apb_cmd_fifo.sv
      - hw/apb_master.sv
      - hw/apb_regbank.sv
      - hw/apb_subsys_top.sv

  # Simulation only
  - target: simulation
    files:
      - tb/apb_protocol_asserts.sv
      - tb/apb_subsys_tb.sv
